/* source/exec_pkg.sv */
package exec_pkg;

	// Machine sizes
	localparam int ROB_SIZE    = 16;
	localparam int ALU_RS_SIZE = 4;
	localparam int MUL_STEPS   = 32;

	typedef logic [31:0] uint32_t;
	typedef logic [63:0] uint64_t;

	typedef logic [$clog2(ROB_SIZE)-1:0]    rob_index_t;
	typedef logic [$clog2(ALU_RS_SIZE)-1:0] rs_index_t;

	// SLT compares signed, shifts take operand 1 bits [4:0]
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL
	} alu_op_t;

	typedef enum logic {
		FU_ALU,
		FU_MUL
	} fu_sel_t;

	// One dispatched instruction
	typedef struct packed {
		uint32_t    [1:0] operand;
		logic       [1:0] operand_ready;
		rob_index_t [1:0] operand_addr;
		alu_op_t          op;
		fu_sel_t          fu;
		rob_index_t       reorder;
	} reserve_station_t;

	typedef struct packed {
		logic       valid;
		rob_index_t reorder;
		uint32_t    value;
	} cdb_packet_t;

endpackage

/* source/result_if.sv */
`timescale 1ns/100ps

interface result_if import exec_pkg::*; (
	input logic clk
);

	uint32_t    data;
	logic       data_ready;
	rob_index_t data_reorder;
	logic       data_ack;

	// Unit holds data until it sees data_ack at an edge
	modport unit (
		output data,
		output data_ready,
		output data_reorder,
		input  data_ack
	);

	modport arbiter (
		input  clk,
		input  data,
		input  data_ready,
		input  data_reorder,
		output data_ack
	);

endinterface

/* source/operand_capture.sv */
`timescale 1ns/100ps

module operand_capture import exec_pkg::*; (
	input  reserve_station_t packet_i,
	output rob_index_t [1:0] rob_raddr_o,
	input  logic       [1:0] rob_rdata_valid_i,
	input  uint32_t    [1:0] rob_rdata_i,
	input  cdb_packet_t      cdb_i,
	output reserve_station_t packet_o
);

logic [1:0] cdb_hit;

assign rob_raddr_o = packet_i.operand_addr;

always_comb begin
	for (int i = 0; i < 2; i++) begin
		cdb_hit[i] = cdb_i.valid && (cdb_i.reorder == packet_i.operand_addr[i]);
	end
end

// Packet value first, then ROB, then this cycle's broadcast
always_comb begin
	packet_o = packet_i;
	for (int i = 0; i < 2; i++) begin
		if (!packet_i.operand_ready[i]) begin
			if (rob_rdata_valid_i[i]) begin
				packet_o.operand[i]       = rob_rdata_i[i];
				packet_o.operand_ready[i] = 1'b1;
			end else if (cdb_hit[i]) begin
				packet_o.operand[i]       = cdb_i.value;
				packet_o.operand_ready[i] = 1'b1;
			end
		end
	end
end

endmodule

/* source/alu_rs.sv */
`timescale 1ns/100ps

module alu_rs import exec_pkg::*; (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             flush_i,
	input  logic             taken_i,
	input  reserve_station_t packet_i,
	input  cdb_packet_t      cdb_i,
	output logic             ready_o,
	result_if.unit           res
);

logic             [ALU_RS_SIZE-1:0] valid;
reserve_station_t [ALU_RS_SIZE-1:0] entry;
rs_index_t        [ALU_RS_SIZE-1:0] rank;
logic             [ALU_RS_SIZE-1:0] ops_ready;

logic [$clog2(ALU_RS_SIZE):0] occupancy;
rs_index_t free_idx;
rs_index_t sel_idx;
rs_index_t new_rank;
logic      sel_found;
logic      issue;
logic      res_free;

uint32_t    src0;
uint32_t    src1;
uint32_t    alu_result;
logic       res_valid;
uint32_t    res_data;
rob_index_t res_reorder;

assign ready_o = ~&valid;

always_comb begin
	occupancy = '0;
	free_idx  = '0;
	for (int i = ALU_RS_SIZE - 1; i >= 0; i--) begin
		ops_ready[i] = valid[i] & (&entry[i].operand_ready);
		occupancy    = occupancy + valid[i];
		if (!valid[i]) begin
			free_idx = rs_index_t'(i);
		end
	end
end

// Oldest entry with both operands, lowest rank wins
always_comb begin
	sel_found = 1'b0;
	sel_idx   = '0;
	for (int i = 0; i < ALU_RS_SIZE; i++) begin
		if (ops_ready[i] && (!sel_found || rank[i] < rank[sel_idx])) begin
			sel_found = 1'b1;
			sel_idx   = rs_index_t'(i);
		end
	end
end

assign res_free = !res_valid || res.data_ack;
assign issue    = sel_found && res_free;
assign new_rank = rs_index_t'(occupancy - issue);

assign src0 = entry[sel_idx].operand[0];
assign src1 = entry[sel_idx].operand[1];

always_comb begin
	case (entry[sel_idx].op)
		ALU_ADD: alu_result = src0 + src1;
		ALU_SUB: alu_result = src0 - src1;
		ALU_AND: alu_result = src0 & src1;
		ALU_OR:  alu_result = src0 | src1;
		ALU_XOR: alu_result = src0 ^ src1;
		ALU_SLT: alu_result = {31'b0, $signed(src0) < $signed(src1)};
		ALU_SLL: alu_result = src0 << src1[4:0];
		ALU_SRL: alu_result = src0 >> src1[4:0];
	endcase
end

always_ff @(posedge clk or negedge rst_n_i) begin
	if (!rst_n_i) begin
		valid <= '0;
		rank  <= '0;
	end else if (flush_i) begin
		valid <= '0;
	end else begin
		// Younger entries move up when one leaves
		for (int i = 0; i < ALU_RS_SIZE; i++) begin
			if (issue && valid[i] && rank[i] > rank[sel_idx]) begin
				rank[i] <= rank[i] - 1'b1;
			end
		end
		if (issue) begin
			valid[sel_idx] <= 1'b0;
		end
		if (taken_i) begin
			valid[free_idx] <= 1'b1;
			rank[free_idx]  <= new_rank;
		end
	end
end

// Operand snooping on the CDB
always_ff @(posedge clk) begin
	for (int i = 0; i < ALU_RS_SIZE; i++) begin
		for (int j = 0; j < 2; j++) begin
			if (!entry[i].operand_ready[j] && cdb_i.valid
					&& cdb_i.reorder == entry[i].operand_addr[j]) begin
				entry[i].operand[j]       <= cdb_i.value;
				entry[i].operand_ready[j] <= 1'b1;
			end
		end
	end
	if (taken_i) begin
		entry[free_idx] <= packet_i;
	end
end

always_ff @(posedge clk or negedge rst_n_i) begin
	if (!rst_n_i) begin
		res_valid <= 1'b0;
	end else if (flush_i) begin
		res_valid <= 1'b0;
	end else if (issue) begin
		res_valid <= 1'b1;
	end else if (res.data_ack) begin
		res_valid <= 1'b0;
	end
end

always_ff @(posedge clk) begin
	if (issue) begin
		res_data    <= alu_result;
		res_reorder <= entry[sel_idx].reorder;
	end
end

assign res.data         = res_data;
assign res.data_ready   = res_valid;
assign res.data_reorder = res_reorder;

a_taken_when_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
	taken_i |-> ready_o)
	else $error("ALU station taken while full");

a_result_held: assert property (@(posedge clk) disable iff (!rst_n_i)
	res_valid && !res.data_ack && !flush_i
	|=> res_valid && $stable(res_data) && $stable(res_reorder))
	else $error("ALU result changed before acknowledge");

endmodule

/* source/mul_rs.sv */
`timescale 1ns/100ps

module mul_rs import exec_pkg::*; (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             flush_i,
	input  logic             taken_i,
	input  reserve_station_t packet_i,
	input  cdb_packet_t      cdb_i,
	output logic             ready_o,
	output uint64_t          hilo_result_o,
	output logic             mul_valid_o,
	result_if.unit           res
);

typedef enum logic [1:0] {
	IDLE,
	WAIT_OPS,
	RUN,
	DONE
} mul_state_t;

mul_state_t       state;
logic [4:0]       cnt;
reserve_station_t entry;
uint64_t          prod;
uint32_t          mcand;
logic [32:0]      step_sum;

// One shift-add step on the upper half
assign step_sum = {1'b0, prod[63:32]} + (prod[0] ? {1'b0, mcand} : 33'b0);

always_ff @(posedge clk or negedge rst_n_i) begin
	if (!rst_n_i) begin
		state <= IDLE;
		cnt   <= '0;
	end else if (flush_i) begin
		state <= IDLE;
		cnt   <= '0;
	end else begin
		case (state)
			IDLE: begin
				if (taken_i) begin
					state <= WAIT_OPS;
				end
			end
			WAIT_OPS: begin
				if (&entry.operand_ready) begin
					state <= RUN;
					cnt   <= '0;
				end
			end
			RUN: begin
				cnt <= cnt + 1'b1;
				if (cnt == 5'(MUL_STEPS - 1)) begin
					state <= DONE;
				end
			end
			DONE: begin
				if (res.data_ack) begin
					state <= IDLE;
				end
			end
		endcase
	end
end

always_ff @(posedge clk) begin
	case (state)
		IDLE: begin
			if (taken_i) begin
				entry <= packet_i;
			end
		end
		WAIT_OPS: begin
			for (int j = 0; j < 2; j++) begin
				if (!entry.operand_ready[j] && cdb_i.valid
						&& cdb_i.reorder == entry.operand_addr[j]) begin
					entry.operand[j]       <= cdb_i.value;
					entry.operand_ready[j] <= 1'b1;
				end
			end
			// Multiplier in the low half, shifted out one bit per step
			prod  <= {32'b0, entry.operand[1]};
			mcand <= entry.operand[0];
		end
		RUN: begin
			prod <= {step_sum, prod[31:1]};
		end
		default: begin
		end
	endcase
end

assign ready_o          = (state == IDLE);
assign res.data         = prod[31:0];
assign res.data_ready   = (state == DONE);
assign res.data_reorder = entry.reorder;

assign hilo_result_o = prod;
assign mul_valid_o   = (state == DONE) && res.data_ack;

a_taken_when_idle: assert property (@(posedge clk) disable iff (!rst_n_i)
	taken_i |-> state == IDLE)
	else $error("Multiplier taken while busy");

endmodule

/* source/cdb_arbiter.sv */
`timescale 1ns/100ps

module cdb_arbiter import exec_pkg::*; (
	result_if.arbiter alu,
	result_if.arbiter mul,
	output cdb_packet_t cdb_o
);

logic mul_wins;

// Multiplier first, it blocks nothing else while waiting
assign mul_wins = mul.data_ready;

assign mul.data_ack = mul.data_ready;
assign alu.data_ack = alu.data_ready && !mul_wins;

always_comb begin
	cdb_o.valid = mul.data_ready || alu.data_ready;
	if (mul_wins) begin
		cdb_o.reorder = mul.data_reorder;
		cdb_o.value   = mul.data;
	end else begin
		cdb_o.reorder = alu.data_reorder;
		cdb_o.value   = alu.data;
	end
end

a_one_ack: assert property (@(posedge mul.clk)
	!(alu.data_ack && mul.data_ack))
	else $error("Both units acknowledged in one cycle");

endmodule

/* source/instr_exec.sv */
`timescale 1ns/100ps

module instr_exec import exec_pkg::*; (
	input  logic             clk,
	input  logic             rst_n_i,
	input  logic             flush_i,

	// Dispatch
	input  logic             issue_valid_i,
	input  fu_sel_t          issue_fu_i,
	input  alu_op_t          issue_op_i,
	input  rob_index_t       issue_reorder_i,
	input  uint32_t    [1:0] issue_operand_i,
	input  logic       [1:0] issue_operand_ready_i,
	input  rob_index_t [1:0] issue_operand_tag_i,

	// ROB read
	output rob_index_t [1:0] rob_raddr_o,
	input  logic       [1:0] rob_rdata_valid_i,
	input  uint32_t    [1:0] rob_rdata_i,

	output logic             alu_ready_o,
	output logic             mul_ready_o,

	// CDB
	output logic             cdb_valid_o,
	output rob_index_t       cdb_reorder_o,
	output uint32_t          cdb_value_o,

	// Full product
	output logic             mul_valid_o,
	output uint64_t          hilo_result_o
);

reserve_station_t issue_packet;
reserve_station_t captured;
cdb_packet_t      cdb;
logic             alu_taken;
logic             mul_taken;

result_if alu_res(.clk);
result_if mul_res(.clk);

assign issue_packet.operand       = issue_operand_i;
assign issue_packet.operand_ready = issue_operand_ready_i;
assign issue_packet.operand_addr  = issue_operand_tag_i;
assign issue_packet.op            = issue_op_i;
assign issue_packet.fu            = issue_fu_i;
assign issue_packet.reorder       = issue_reorder_i;

assign alu_taken = issue_valid_i && (issue_fu_i == FU_ALU);
assign mul_taken = issue_valid_i && (issue_fu_i == FU_MUL);

assign cdb_valid_o   = cdb.valid;
assign cdb_reorder_o = cdb.reorder;
assign cdb_value_o   = cdb.value;

operand_capture operand_capture_inst(
	.packet_i          ( issue_packet      ),
	.rob_raddr_o       ( rob_raddr_o       ),
	.rob_rdata_valid_i ( rob_rdata_valid_i ),
	.rob_rdata_i       ( rob_rdata_i       ),
	.cdb_i             ( cdb               ),
	.packet_o          ( captured          )
);

alu_rs alu_rs_inst(
	.clk,
	.rst_n_i,
	.flush_i,
	.taken_i  ( alu_taken   ),
	.packet_i ( captured    ),
	.cdb_i    ( cdb         ),
	.ready_o  ( alu_ready_o ),
	.res      ( alu_res     )
);

mul_rs mul_rs_inst(
	.clk,
	.rst_n_i,
	.flush_i,
	.taken_i       ( mul_taken     ),
	.packet_i      ( captured      ),
	.cdb_i         ( cdb           ),
	.ready_o       ( mul_ready_o   ),
	.hilo_result_o ( hilo_result_o ),
	.mul_valid_o   ( mul_valid_o   ),
	.res           ( mul_res       )
);

cdb_arbiter cdb_arbiter_inst(
	.alu   ( alu_res ),
	.mul   ( mul_res ),
	.cdb_o ( cdb     )
);

endmodule

/* tb/tb_instr_exec.sv */
`timescale 1ns/100ps

module tb_instr_exec import exec_pkg::*; ();

localparam int TIMEOUT = 200;
localparam int SEED    = 62986;

typedef enum logic [1:0] {
	SRC_IMM,
	SRC_RND,
	SRC_ROB,
	SRC_TAG
} src_t;

typedef enum logic [1:0] {
	CTL_NONE,
	CTL_DRAIN,
	CTL_FULL,
	CTL_FLUSH
} ctl_t;

// A negative gap means a random number of idle cycles
typedef struct packed {
	fu_sel_t    fu;
	alu_op_t    op;
	rob_index_t tag;
	src_t       m0;
	uint32_t    v0;
	src_t       m1;
	uint32_t    v1;
	int         gap;
	ctl_t       ctl;
} row_t;

logic             clk;
logic             rst_n_i;
logic             flush_i;
logic             issue_valid_i;
fu_sel_t          issue_fu_i;
alu_op_t          issue_op_i;
rob_index_t       issue_reorder_i;
uint32_t    [1:0] issue_operand_i;
logic       [1:0] issue_operand_ready_i;
rob_index_t [1:0] issue_operand_tag_i;
rob_index_t [1:0] rob_raddr_o;
logic       [1:0] rob_rdata_valid_i;
uint32_t    [1:0] rob_rdata_i;
logic             alu_ready_o;
logic             mul_ready_o;
logic             cdb_valid_o;
rob_index_t       cdb_reorder_o;
uint32_t          cdb_value_o;
logic             mul_valid_o;
uint64_t          hilo_result_o;

// Scoreboard indexed by reorder tag
uint32_t exp_val [ROB_SIZE];
uint32_t rob_val [ROB_SIZE];
logic    pending [ROB_SIZE];
logic    is_mul  [ROB_SIZE];
uint64_t mul_hilo;
row_t    rows [$];
int      seed_init;
int      ngap;

instr_exec dut0 (.*);

initial begin
	clk = 1'b0;
	forever #50 clk = ~clk;
end

task automatic fail_run(input string what);
	$display("%s", what);
	$display("Simulation failed");
	$fatal(1, "Run stopped");
endtask

task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
		input string what);
	if (actual !== expected) begin
		$display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
		$display("Simulation failed");
		$fatal(1, "Run stopped at first mismatch");
	end
endtask

function automatic uint32_t alu_ref(input alu_op_t op, input uint32_t a, input uint32_t b);
	case (op)
		ALU_ADD: return a + b;
		ALU_SUB: return a - b;
		ALU_AND: return a & b;
		ALU_OR:  return a | b;
		ALU_XOR: return a ^ b;
		ALU_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		ALU_SLL: return a << b[4:0];
		default: return a >> b[4:0];
	endcase
endfunction

function automatic int pending_count();
	int n;
	n = 0;
	for (int i = 0; i < ROB_SIZE; i++) begin
		n += pending[i];
	end
	return n;
endfunction

task automatic add_row(input fu_sel_t fu, input alu_op_t op, input rob_index_t tag,
		input src_t m0, input uint32_t v0, input src_t m1, input uint32_t v1,
		input int gap, input ctl_t ctl);
	rows.push_back({fu, op, tag, m0, v0, m1, v1, gap, ctl});
endtask

task automatic idle_cycle();
	@(posedge clk);
	issue_valid_i     <= 1'b0;
	rob_rdata_valid_i <= 2'b00;
	@(negedge clk);
endtask

task automatic wait_drain();
	int n;
	n = 0;
	@(posedge clk);
	issue_valid_i     <= 1'b0;
	rob_rdata_valid_i <= 2'b00;
	while (pending_count() != 0) begin
		n++;
		if (n > TIMEOUT) begin
			fail_run("Timeout: outstanding results never appeared on the CDB");
		end
		@(posedge clk);
	end
	@(negedge clk);
endtask

task automatic apply_flush();
	@(posedge clk);
	issue_valid_i     <= 1'b0;
	rob_rdata_valid_i <= 2'b00;
	flush_i           <= 1'b1;
	@(posedge clk);
	flush_i <= 1'b0;
	for (int i = 0; i < ROB_SIZE; i++) begin
		pending[i] = 1'b0;
	end
	@(negedge clk);
	check_value(alu_ready_o, 1'b1, "alu_ready_o after flush");
	check_value(mul_ready_o, 1'b1, "mul_ready_o after flush");
endtask

task automatic issue_row(input row_t r);
	int               n;
	src_t             mode [2];
	uint32_t          val [2];
	uint32_t          opv [2];
	uint32_t    [1:0] drv;
	logic       [1:0] rdy;
	rob_index_t [1:0] tg;
	logic       [1:0] rv;
	uint32_t    [1:0] rd;
	uint64_t          prod;
	uint32_t          expv;
	mode[0] = r.m0;
	mode[1] = r.m1;
	val[0]  = r.v0;
	val[1]  = r.v1;
	n = 0;
	// The unit takes a dispatch still in flight only at the next edge
	if (issue_valid_i === 1'b1 && issue_fu_i == r.fu) begin
		idle_cycle();
	end
	while (((r.fu == FU_ALU) ? alu_ready_o : mul_ready_o) !== 1'b1) begin
		idle_cycle();
		n++;
		if (n > TIMEOUT) begin
			fail_run("Timeout: selected unit never became ready for dispatch");
		end
	end
	for (int j = 0; j < 2; j++) begin
		rdy[j] = 1'b0;
		tg[j]  = '0;
		rv[j]  = 1'b0;
		rd[j]  = '0;
		case (mode[j])
			SRC_IMM: opv[j] = val[j];
			SRC_RND: opv[j] = $urandom;
			SRC_ROB: begin
				opv[j] = val[j];
				tg[j]  = rob_index_t'(j + 8);
				rv[j]  = 1'b1;
				rd[j]  = val[j];
			end
			default: begin
				tg[j]  = rob_index_t'(val[j]);
				opv[j] = rob_val[tg[j]];
			end
		endcase
		rdy[j] = (mode[j] == SRC_IMM) || (mode[j] == SRC_RND);
		// Stale packet value that the ROB or CDB has to replace
		drv[j] = rdy[j] ? opv[j] : ~opv[j];
	end
	if (r.fu == FU_MUL) begin
		prod = {32'b0, opv[0]} * {32'b0, opv[1]};
		expv = prod[31:0];
	end else begin
		prod = '0;
		expv = alu_ref(r.op, opv[0], opv[1]);
	end
	@(posedge clk);
	issue_valid_i         <= 1'b1;
	issue_fu_i            <= r.fu;
	issue_op_i            <= r.op;
	issue_reorder_i       <= r.tag;
	issue_operand_i       <= drv;
	issue_operand_ready_i <= rdy;
	issue_operand_tag_i   <= tg;
	rob_rdata_valid_i     <= rv;
	rob_rdata_i           <= rd;
	exp_val[r.tag] = expv;
	rob_val[r.tag] = expv;
	pending[r.tag] = 1'b1;
	is_mul[r.tag]  = (r.fu == FU_MUL);
	if (r.fu == FU_MUL) begin
		mul_hilo = prod;
	end
	@(negedge clk);
	check_value(rob_raddr_o, tg, "ROB read address");
	if (r.ctl == CTL_FULL) begin
		idle_cycle();
		check_value(alu_ready_o, 1'b0, "alu_ready_o with four waiting entries");
	end
endtask

task automatic check_broadcast();
	rob_index_t t;
	t = cdb_reorder_o;
	if (cdb_valid_o === 1'b1) begin
		check_value(pending[t], 1'b1, "CDB broadcast for a tag with nothing outstanding");
		check_value(cdb_value_o, exp_val[t], "CDB value");
		check_value(mul_valid_o, is_mul[t], "mul_valid_o during a broadcast");
		if (mul_valid_o) begin
			check_value(hilo_result_o, mul_hilo, "Full product on hilo_result_o");
		end
		pending[t] = 1'b0;
	end else begin
		check_value(cdb_valid_o, 1'b0, "cdb_valid_o level");
		check_value(mul_valid_o, 1'b0, "mul_valid_o without a broadcast");
	end
endtask

// CDB monitor
initial begin
	forever begin
		@(negedge clk);
		if (rst_n_i === 1'b1) begin
			check_broadcast();
		end
	end
end

initial begin
	seed_init             = $urandom(SEED);
	rst_n_i               = 1'b0;
	flush_i               = 1'b0;
	issue_valid_i         = 1'b0;
	issue_fu_i            = FU_ALU;
	issue_op_i            = ALU_ADD;
	issue_reorder_i       = '0;
	issue_operand_i       = '0;
	issue_operand_ready_i = '0;
	issue_operand_tag_i   = '0;
	rob_rdata_valid_i     = '0;
	rob_rdata_i           = '0;
	mul_hilo              = '0;
	for (int i = 0; i < ROB_SIZE; i++) begin
		exp_val[i] = '0;
		rob_val[i] = '0;
		pending[i] = 1'b0;
		is_mul[i]  = 1'b0;
	end

	// Every ALU opcode
	add_row(FU_ALU, ALU_ADD, 4'd1, SRC_IMM, 32'd5, SRC_IMM, 32'd7, -1, CTL_NONE);
	add_row(FU_ALU, ALU_SUB, 4'd2, SRC_IMM, 32'd3, SRC_IMM, 32'd10, -1, CTL_NONE);
	add_row(FU_ALU, ALU_AND, 4'd3, SRC_RND, 32'd0, SRC_RND, 32'd0, -1, CTL_NONE);
	add_row(FU_ALU, ALU_OR, 4'd4, SRC_IMM, 32'hf0f0_0000, SRC_IMM, 32'h0f0f, 0, CTL_NONE);
	add_row(FU_ALU, ALU_XOR, 4'd5, SRC_RND, 32'd0, SRC_RND, 32'd0, 0, CTL_NONE);
	add_row(FU_ALU, ALU_SLT, 4'd6, SRC_IMM, 32'hffff_fffb, SRC_IMM, 32'd3, -1, CTL_NONE);
	add_row(FU_ALU, ALU_SLT, 4'd7, SRC_IMM, 32'd3, SRC_IMM, 32'hffff_fffb, -1, CTL_NONE);
	add_row(FU_ALU, ALU_SLL, 4'd8, SRC_IMM, 32'd3, SRC_IMM, 32'd36, 0, CTL_NONE);
	add_row(FU_ALU, ALU_SRL, 4'd9, SRC_IMM, 32'h8000_0000, SRC_IMM, 32'hffff_ffff, 0, CTL_NONE);
	// Operands from the ROB
	add_row(FU_ALU, ALU_ADD, 4'd10, SRC_ROB, 32'd100, SRC_IMM, 32'd23, -1, CTL_NONE);
	add_row(FU_ALU, ALU_SUB, 4'd11, SRC_IMM, 32'd1000, SRC_ROB, 32'd1, -1, CTL_NONE);
	add_row(FU_ALU, ALU_XOR, 4'd12, SRC_ROB, 32'h1234_5678, SRC_ROB, 32'h0f0f_0f0f, 0, CTL_NONE);
	// Dependent ones see the producer on the CDB in their issue cycle
	add_row(FU_ALU, ALU_ADD, 4'd13, SRC_IMM, 32'd1, SRC_IMM, 32'd2, 0, CTL_DRAIN);
	add_row(FU_ALU, ALU_ADD, 4'd14, SRC_TAG, 32'd13, SRC_IMM, 32'd10, 1, CTL_NONE);
	add_row(FU_ALU, ALU_SUB, 4'd15, SRC_TAG, 32'd14, SRC_ROB, 32'd3, 0, CTL_NONE);
	// Multiplies
	add_row(FU_MUL, ALU_ADD, 4'd1, SRC_RND, 32'd0, SRC_RND, 32'd0, -1, CTL_DRAIN);
	add_row(FU_MUL, ALU_ADD, 4'd2, SRC_RND, 32'd0, SRC_RND, 32'd0, -1, CTL_NONE);
	add_row(FU_MUL, ALU_ADD, 4'd3, SRC_IMM, 32'hffff_ffff, SRC_IMM, 32'hffff_ffff, -1, CTL_NONE);
	add_row(FU_MUL, ALU_ADD, 4'd4, SRC_IMM, 32'd0, SRC_RND, 32'd0, -1, CTL_NONE);
	// Full ALU station behind one multiply
	add_row(FU_MUL, ALU_ADD, 4'd5, SRC_RND, 32'd0, SRC_RND, 32'd0, 0, CTL_DRAIN);
	add_row(FU_ALU, ALU_ADD, 4'd6, SRC_TAG, 32'd5, SRC_IMM, 32'd1, 0, CTL_NONE);
	add_row(FU_ALU, ALU_SUB, 4'd7, SRC_TAG, 32'd5, SRC_RND, 32'd0, 0, CTL_NONE);
	add_row(FU_ALU, ALU_XOR, 4'd8, SRC_RND, 32'd0, SRC_TAG, 32'd5, 0, CTL_NONE);
	add_row(FU_ALU, ALU_SRL, 4'd9, SRC_TAG, 32'd5, SRC_IMM, 32'd4, 0, CTL_FULL);
	// Tag 0 is never produced, so these wait until the flush
	add_row(FU_MUL, ALU_ADD, 4'd10, SRC_TAG, 32'd0, SRC_RND, 32'd0, 0, CTL_DRAIN);
	add_row(FU_ALU, ALU_ADD, 4'd11, SRC_TAG, 32'd10, SRC_IMM, 32'd1, 0, CTL_NONE);
	add_row(FU_ALU, ALU_AND, 4'd12, SRC_TAG, 32'd0, SRC_IMM, 32'hff, 0, CTL_NONE);
	add_row(FU_ALU, ALU_ADD, 4'd13, SRC_IMM, 32'd4, SRC_IMM, 32'd5, 0, CTL_FLUSH);
	add_row(FU_ALU, ALU_ADD, 4'd14, SRC_IMM, 32'd6, SRC_IMM, 32'd7, -1, CTL_NONE);
	add_row(FU_MUL, ALU_ADD, 4'd15, SRC_RND, 32'd0, SRC_RND, 32'd0, -1, CTL_NONE);
	add_row(FU_ALU, ALU_OR, 4'd1, SRC_TAG, 32'd15, SRC_IMM, 32'd1, 0, CTL_NONE);

	repeat (16) @(posedge clk);
	rst_n_i <= 1'b1;
	@(negedge clk);
	check_value(cdb_valid_o, 1'b0, "cdb_valid_o after reset");
	check_value(mul_valid_o, 1'b0, "mul_valid_o after reset");
	check_value(alu_ready_o, 1'b1, "alu_ready_o after reset");
	check_value(mul_ready_o, 1'b1, "mul_ready_o after reset");

	foreach (rows[i]) begin
		if (rows[i].ctl == CTL_DRAIN) begin
			wait_drain();
		end
		ngap = (rows[i].gap < 0) ? int'($urandom % 4) : rows[i].gap;
		repeat (ngap) idle_cycle();
		issue_row(rows[i]);
		if (rows[i].ctl == CTL_FLUSH) begin
			apply_flush();
		end
	end
	wait_drain();
	check_value(alu_ready_o, 1'b1, "alu_ready_o at the end");
	check_value(mul_ready_o, 1'b1, "mul_ready_o at the end");
	$display("Simulation completed successfully");
	$finish;
end

endmodule

/* exec_core.f */
source/exec_pkg.sv
source/result_if.sv
source/operand_capture.sv
source/alu_rs.sv
source/mul_rs.sv
source/cdb_arbiter.sv
source/instr_exec.sv
tb/tb_instr_exec.sv
